//--- flist.f
verilog/cache_pkg.sv
verilog/bus_pkg.sv
verilog/single_port_ram.sv
verilog/dcache.sv
verilog/cbus_memory.sv
verilog/dcache_top.sv
tests/dcache_checker.sv
tests/dcache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the dcache testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module dcache_tb -f flist.f -o Vdcache_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vdcache_tb +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^all tests passed$" "$log"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $log"
	exit 1
fi

//--- tests/dcache_checker.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_checker (
	input  logic clk,
	input  logic reset,
	input  bus_pkg::dbus_req_t dreq,
	input  bus_pkg::dbus_resp_t dresp,
	input  bus_pkg::cbus_req_t creq,
	input  bus_pkg::cbus_resp_t cresp
);

	// number of assertion failures so far
	int failures = 0;

	// an answer only ever goes to a held request
	data_ok_needs_valid: assert property (@(posedge clk) disable iff (reset)
		dresp.data_ok |-> dreq.valid)
		else begin
			$error("data_ok raised without a valid dbus request");
			failures++;
		end

	// write data changes per beat, the rest of the request must hold
	creq_held_stable: assert property (@(posedge clk) disable iff (reset)
		creq.valid && !(cresp.ready && cresp.last) |=> creq.valid
			&& $stable(creq.addr) && $stable(creq.is_write) && $stable(creq.size)
			&& $stable(creq.strobe) && $stable(creq.len) && $stable(creq.burst))
		else begin
			$error("cbus request changed or dropped before its last beat");
			failures++;
		end

	creq_drops_after_last: assert property (@(posedge clk) disable iff (reset)
		creq.valid && cresp.ready && cresp.last |=> !creq.valid)
		else begin
			$error("cbus request still valid after its last beat");
			failures++;
		end

	// controller comes out of reset quiet
	quiet_after_reset: assert property (@(posedge clk)
		reset |=> !creq.valid && !dresp.data_ok)
		else begin
			$error("cbus valid or data_ok raised in the cycle after reset");
			failures++;
		end

endmodule

`default_nettype wire

//--- tests/dcache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_tb;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 10;
	localparam int MAX_VECTORS = 64;
	localparam int FIELDS = 5;
	localparam int CYCLES_PER_VECTOR = 200;

	logic clk;
	logic reset;
	bus_pkg::dbus_req_t dreq;
	bus_pkg::dbus_resp_t dresp;

	// five words per vector: op, address, strobe, write data, expected data
	logic [63:0] vec_mem [MAX_VECTORS * FIELDS];
	int num_vectors;
	int num_pass;
	int num_fail;
	logic loaded = 1'b0;

	dcache_top uut (
		.clk(clk),
		.reset(reset),
		.dreq(dreq),
		.dresp(dresp)
	);

	bind dcache dcache_checker u_checker (
		.clk(clk),
		.reset(reset),
		.dreq(dreq),
		.dresp(dresp),
		.creq(creq),
		.cresp(cresp)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic load_vectors();
		for (int i = 0; i < MAX_VECTORS * FIELDS; i++) begin
			vec_mem[i] = '1;
		end
		$readmemh("tests/dcache_vectors.txt", vec_mem);
		// unused slots keep the all-ones fill
		num_vectors = 0;
		while (num_vectors < MAX_VECTORS && vec_mem[num_vectors * FIELDS] != '1) begin
			num_vectors++;
		end
	endtask

	// hold the request until data_ok or the cycle limit, sampled mid-cycle
	task automatic run_access(input int n, output bus_pkg::dbus_resp_t resp);
		int base;
		int waited;
		base = n * FIELDS;
		waited = 0;
		@(negedge clk);
		dreq.valid = 1'b1;
		dreq.addr = vec_mem[base + 1][31:0];
		dreq.size = bus_pkg::MSIZE8;
		dreq.strobe = vec_mem[base + 2][7:0];
		dreq.data = vec_mem[base + 3];
		do begin
			@(negedge clk);
			waited++;
		end while (!dresp.data_ok && waited < CYCLES_PER_VECTOR);
		resp = dresp;
	endtask

	task automatic check_resp(input int n, input cache_pkg::addr_t addr,
			input bus_pkg::dbus_resp_t got, input cache_pkg::word_t expected);
		if (got.data_ok !== 1'b1) begin
			num_fail++;
			$display("test %0d read %h: the read never completed", n, addr);
		end else if (got.data === expected) begin
			num_pass++;
			$display("test %0d read %h: ok, data %h", n, addr, got.data);
		end else begin
			num_fail++;
			$display("[FAIL] test %0d read %h: dresp.data = %h, expected %h",
				n, addr, got.data, expected);
		end
	endtask

	task automatic check_write_done(input int n, input cache_pkg::addr_t addr,
			input bus_pkg::dbus_resp_t got);
		if (got.data_ok === 1'b1) begin
			num_pass++;
			$display("test %0d write %h: ok, completed", n, addr);
		end else begin
			num_fail++;
			$display("test %0d write %h: the write never completed", n, addr);
		end
	endtask

	initial begin
		bus_pkg::dbus_resp_t resp;
		int base;
		int assert_fails;
		dreq = '0;
		reset = 1'b1;
		num_pass = 0;
		num_fail = 0;
		load_vectors();
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		if (num_vectors == 0) begin
			$display("no vectors were read from tests/dcache_vectors.txt");
			num_fail++;
		end
		for (int n = 0; n < num_vectors; n++) begin
			base = n * FIELDS;
			run_access(n, resp);
			if (vec_mem[base] == 64'd1) begin
				check_write_done(n, vec_mem[base + 1][31:0], resp);
			end else begin
				check_resp(n, vec_mem[base + 1][31:0], resp, vec_mem[base + 4]);
			end
		end
		@(negedge clk);
		dreq.valid = 1'b0;
		repeat (2) @(negedge clk);
		assert_fails = uut.u_dcache.u_checker.failures;
		if (assert_fails != 0) begin
			$display("protocol assertions in dcache fired %0d times", assert_fails);
		end
		$display("%0d vectors run, %0d passed, %0d failed, %0d assertion failures",
			num_vectors, num_pass, num_fail, assert_fails);
		if (num_fail == 0 && assert_fails == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// budget scales with the number of vectors
	initial begin
		wait (loaded);
		#((RESET_CYCLES + num_vectors * CYCLES_PER_VECTOR) * CLK_PERIOD);
		$display("timeout: a request never completed with data_ok");
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/dcache_vectors.txt
// op (0 read, 1 write), address, strobe, write data, expected read data
// expected data of a write is not checked
0 80000000 00 0000000000000000 c0de000080000000
0 80000048 00 0000000000000000 c0de000980000048
0 800000f8 00 0000000000000000 c0de001f800000f8
0 80000080 00 0000000000000000 c0de001080000080
0 80000088 00 0000000000000000 c0de001180000088
0 80000090 00 0000000000000000 c0de001280000090
0 80000098 00 0000000000000000 c0de001380000098
0 800000b8 00 0000000000000000 c0de0017800000b8
1 80000008 0f 1122334455667788 0000000000000000
0 80000008 00 0000000000000000 c0de000155667788
1 80000010 f0 aabbccddeeff0011 0000000000000000
0 80000010 00 0000000000000000 aabbccdd80000010
1 80000018 81 99000000000000aa 0000000000000000
0 80000018 00 0000000000000000 99de0003800000aa
0 80000400 00 0000000000000000 c0de008080000400
0 80000008 00 0000000000000000 c0de000155667788
0 80000018 00 0000000000000000 99de0003800000aa
1 80000440 ff deadbeefcafef00d 0000000000000000
0 80000040 00 0000000000000000 c0de000880000040
0 80000440 00 0000000000000000 deadbeefcafef00d
0 800004f8 00 0000000000000000 c0de009f800004f8
0 800000f8 00 0000000000000000 c0de001f800000f8
0 10000008 00 0000000000000000 0000000000000000
1 10000000 ff 123456789abcdef0 0000000000000000
0 10000000 00 0000000000000000 123456789abcdef0
1 10000000 ff 0f0e0d0c0b0a0908 0000000000000000
0 10000000 00 0000000000000000 0f0e0d0c0b0a0908
1 10000018 03 000000000000beef 0000000000000000
0 10000018 00 0000000000000000 000000000000beef

//--- verilog/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// access size, log2 of the byte count
	typedef enum logic [2:0] {
		MSIZE1 = 3'd0,
		MSIZE2 = 3'd1,
		MSIZE4 = 3'd2,
		MSIZE8 = 3'd3
	} msize_t;

	// burst length, encoded as beats minus one
	typedef enum logic [7:0] {
		MLEN1 = 8'd0,
		MLEN8 = 8'd7
	} mlen_t;

	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01
	} burst_t;

	// core side, an empty strobe means a read
	typedef struct packed {
		logic valid;
		cache_pkg::addr_t addr;
		msize_t size;
		cache_pkg::strobe_t strobe;
		cache_pkg::word_t data;
	} dbus_req_t;

	typedef struct packed {
		logic data_ok;
		cache_pkg::word_t data;
	} dbus_resp_t;

	// memory side
	typedef struct packed {
		logic valid;
		logic is_write;
		cache_pkg::addr_t addr;
		msize_t size;
		cache_pkg::strobe_t strobe;
		cache_pkg::word_t data;
		mlen_t len;
		burst_t burst;
	} cbus_req_t;

	typedef struct packed {
		logic ready;
		logic last;
		cache_pkg::word_t data;
	} cbus_resp_t;

endpackage

`default_nettype wire

//--- verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

	// basic widths of the data path
	parameter int ADDR_BITS = 32;
	parameter int WORD_BYTES = 8;
	parameter int WORD_BITS = 8 * WORD_BYTES;

	typedef logic [ADDR_BITS-1:0] addr_t;
	typedef logic [WORD_BITS-1:0] word_t;

	// one enable bit per byte of a word
	typedef logic [WORD_BYTES-1:0] strobe_t;

	// top address nibble of the cacheable region
	parameter logic [3:0] CACHED_NIBBLE = 4'h8;

	// everything outside this region is device space
	function automatic logic is_cached(addr_t addr);
		return addr[ADDR_BITS-1 -: 4] == CACHED_NIBBLE;
	endfunction

endpackage

`default_nettype wire

//--- verilog/cbus_memory.sv
`timescale 1ns/100ps
`default_nettype none

module cbus_memory #(
	parameter int MEM_WORDS = 256,
	parameter int RESP_DELAY = 2
) (
	input  logic clk,
	input  logic reset,
	input  bus_pkg::cbus_req_t creq,
	output bus_pkg::cbus_resp_t cresp
);

	localparam int ALIGN_BITS = $clog2(cache_pkg::WORD_BYTES);
	localparam int INDEX_BITS = $clog2(MEM_WORDS);
	localparam int DELAY_BITS = $clog2(RESP_DELAY + 1);
	localparam int NUM_REGS = 4;
	localparam int REG_BITS = $clog2(NUM_REGS);

	cache_pkg::word_t mem [MEM_WORDS];
	cache_pkg::word_t dev_regs [NUM_REGS];

	logic busy;
	logic [DELAY_BITS-1:0] delay_cnt;
	logic [7:0] beat;
	logic ready;
	logic cached;
	logic [INDEX_BITS-1:0] beat_step;
	logic [INDEX_BITS-1:0] word_idx;
	logic [REG_BITS-1:0] reg_idx;

	assign cached = cache_pkg::is_cached(creq.addr);

	// fixed bursts stay on the start word
	assign beat_step = creq.burst == bus_pkg::BURST_INCR ? INDEX_BITS'(beat) : '0;
	assign word_idx = creq.addr[ALIGN_BITS +: INDEX_BITS] + beat_step;
	assign reg_idx = creq.addr[ALIGN_BITS +: REG_BITS];

	assign ready = busy && delay_cnt == DELAY_BITS'(RESP_DELAY);

	assign cresp.ready = ready;
	assign cresp.last = ready && beat == creq.len;
	assign cresp.data = cached ? mem[word_idx] : dev_regs[reg_idx];

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			delay_cnt <= '0;
			beat <= '0;
			// upper half tags the word index, lower half is its byte address
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= {32'hC0DE_0000 + 32'(i), cache_pkg::CACHED_NIBBLE,
					28'(i * cache_pkg::WORD_BYTES)};
			end
			for (int r = 0; r < NUM_REGS; r++) begin
				dev_regs[r] <= '0;
			end
		end else if (!busy) begin
			delay_cnt <= DELAY_BITS'(1);
			beat <= '0;
			busy <= creq.valid;
		end else if (!ready) begin
			delay_cnt <= delay_cnt + 1'b1;
		end else begin
			beat <= beat + 1'b1;
			if (beat == creq.len) begin
				busy <= 1'b0;
			end
			if (creq.is_write) begin
				for (int b = 0; b < cache_pkg::WORD_BYTES; b++) begin
					if (creq.strobe[b] && cached) begin
						mem[word_idx][b*8 +: 8] <= creq.data[b*8 +: 8];
					end else if (creq.strobe[b]) begin
						dev_regs[reg_idx][b*8 +: 8] <= creq.data[b*8 +: 8];
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/dcache.sv
`timescale 1ns/100ps
`default_nettype none

module dcache #(
	parameter int NUM_LINES = 16,
	parameter int WORDS_PER_LINE = 8
) (
	input  logic clk,
	input  logic reset,
	input  bus_pkg::dbus_req_t dreq,
	output bus_pkg::dbus_resp_t dresp,
	output bus_pkg::cbus_req_t creq,
	input  bus_pkg::cbus_resp_t cresp
);

	localparam int ALIGN_BITS = $clog2(cache_pkg::WORD_BYTES);
	localparam int OFFSET_BITS = $clog2(WORDS_PER_LINE);
	localparam int INDEX_BITS = $clog2(NUM_LINES);
	localparam int TAG_BITS = cache_pkg::ADDR_BITS - INDEX_BITS - OFFSET_BITS - ALIGN_BITS;

	typedef struct packed {
		logic valid;
		logic dirty;
		logic [TAG_BITS-1:0] tag;
	} line_meta_t;

	localparam int META_BYTES = ($bits(line_meta_t) + 7) / 8;

	typedef enum logic [2:0] {
		S_INIT,
		S_IDLE,
		S_LOOKUP,
		S_WRITEBACK,
		S_REFILL,
		S_UNCACHED
	} state_t;

	state_t state, state_nxt;
	logic [OFFSET_BITS-1:0] beat, beat_nxt;
	logic [INDEX_BITS-1:0] init_idx;

	// address split of the current request
	logic [TAG_BITS-1:0] req_tag;
	logic [INDEX_BITS-1:0] req_index;
	logic [OFFSET_BITS-1:0] req_offset;
	logic uncached;

	assign req_tag = dreq.addr[cache_pkg::ADDR_BITS-1 -: TAG_BITS];
	assign req_index = dreq.addr[ALIGN_BITS + OFFSET_BITS +: INDEX_BITS];
	assign req_offset = dreq.addr[ALIGN_BITS +: OFFSET_BITS];
	assign uncached = !cache_pkg::is_cached(dreq.addr);

	line_meta_t meta_rd, meta_wr;
	logic meta_we;
	logic [INDEX_BITS-1:0] meta_addr;
	logic [META_BYTES-1:0] meta_strobe;

	cache_pkg::word_t data_rd, data_wr;
	cache_pkg::strobe_t data_strobe;
	logic [OFFSET_BITS-1:0] ram_offset;

	logic hit;

	assign hit = meta_rd.valid && meta_rd.tag == req_tag;

	always_comb begin
		state_nxt = state;
		beat_nxt = beat;
		meta_we = 1'b0;
		meta_wr.valid = 1'b1;
		meta_wr.dirty = 1'b0;
		meta_wr.tag = req_tag;
		data_strobe = '0;
		data_wr = dreq.data;
		ram_offset = req_offset;
		unique case (state)
			S_INIT: begin
				// clear one line of metadata per cycle
				meta_we = 1'b1;
				meta_wr.valid = 1'b0;
				meta_wr.tag = '0;
				if (init_idx == INDEX_BITS'(NUM_LINES - 1)) begin
					state_nxt = S_IDLE;
				end
			end
			S_IDLE: begin
				beat_nxt = '0;
				if (dreq.valid) begin
					state_nxt = uncached ? S_UNCACHED : S_LOOKUP;
				end
			end
			S_LOOKUP: begin
				if (hit) begin
					state_nxt = S_IDLE;
					if (|dreq.strobe) begin
						data_strobe = dreq.strobe;
						meta_we = 1'b1;
						meta_wr.dirty = 1'b1;
					end
				end else begin
					// start reading the victim at word 0
					ram_offset = '0;
					if (meta_rd.valid && meta_rd.dirty) begin
						state_nxt = S_WRITEBACK;
					end else begin
						state_nxt = S_REFILL;
					end
				end
			end
			S_WRITEBACK: begin
				if (cresp.ready) begin
					beat_nxt = beat + 1'b1;
					if (cresp.last) begin
						// line is clean now, the relookup starts the refill
						meta_we = 1'b1;
						meta_wr.tag = meta_rd.tag;
						state_nxt = S_IDLE;
					end
				end
				// fetch the word for the next beat one cycle early
				ram_offset = beat_nxt;
			end
			S_REFILL: begin
				ram_offset = beat;
				if (cresp.ready) begin
					data_strobe = '1;
					data_wr = cresp.data;
					beat_nxt = beat + 1'b1;
					if (cresp.last) begin
						meta_we = 1'b1;
						state_nxt = S_IDLE;
					end
				end
			end
			S_UNCACHED: begin
				if (cresp.ready) begin
					state_nxt = S_IDLE;
				end
			end
			default: begin
				state_nxt = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_INIT;
			beat <= '0;
			init_idx <= '0;
		end else begin
			state <= state_nxt;
			beat <= beat_nxt;
			if (state == S_INIT) begin
				init_idx <= init_idx + 1'b1;
			end
		end
	end

	assign dresp.data_ok = (state == S_LOOKUP && hit) || (state == S_UNCACHED && cresp.ready);
	assign dresp.data = state == S_UNCACHED ? cresp.data : data_rd;

	// defaults describe a line refill
	always_comb begin
		creq.valid = 1'b0;
		creq.is_write = 1'b0;
		creq.addr = {req_tag, req_index, {(OFFSET_BITS + ALIGN_BITS){1'b0}}};
		creq.size = bus_pkg::MSIZE8;
		creq.strobe = '1;
		creq.data = data_rd;
		creq.len = bus_pkg::MLEN8;
		creq.burst = bus_pkg::BURST_INCR;
		unique case (state)
			S_WRITEBACK: begin
				creq.valid = 1'b1;
				creq.is_write = 1'b1;
				creq.addr = {meta_rd.tag, req_index, {(OFFSET_BITS + ALIGN_BITS){1'b0}}};
			end
			S_REFILL: begin
				creq.valid = 1'b1;
			end
			S_UNCACHED: begin
				creq.valid = 1'b1;
				creq.is_write = |dreq.strobe;
				creq.addr = dreq.addr;
				creq.size = dreq.size;
				creq.strobe = dreq.strobe;
				creq.data = dreq.data;
				creq.len = bus_pkg::MLEN1;
				creq.burst = bus_pkg::BURST_FIXED;
			end
			default: begin
				creq.valid = 1'b0;
			end
		endcase
	end

	assign meta_addr = state == S_INIT ? init_idx : req_index;
	assign meta_strobe = meta_we ? '1 : '0;

	single_port_ram #(
		.data_t(line_meta_t),
		.DEPTH(NUM_LINES)
	) meta_ram (
		.clk(clk),
		.addr(meta_addr),
		.strobe(meta_strobe),
		.wdata(meta_wr),
		.rdata(meta_rd)
	);

	single_port_ram #(
		.data_t(cache_pkg::word_t),
		.DEPTH(NUM_LINES * WORDS_PER_LINE)
	) data_ram (
		.clk(clk),
		.addr({req_index, ram_offset}),
		.strobe(data_strobe),
		.wdata(data_wr),
		.rdata(data_rd)
	);

endmodule

`default_nettype wire

//--- verilog/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_top #(
	parameter int NUM_LINES = 16,
	parameter int WORDS_PER_LINE = 8,
	parameter int MEM_WORDS = 256,
	parameter int RESP_DELAY = 2
) (
	input  logic clk,
	input  logic reset,
	input  bus_pkg::dbus_req_t dreq,
	output bus_pkg::dbus_resp_t dresp
);

	// memory side of the cache
	bus_pkg::cbus_req_t creq;
	bus_pkg::cbus_resp_t cresp;

	dcache #(
		.NUM_LINES(NUM_LINES),
		.WORDS_PER_LINE(WORDS_PER_LINE)
	) u_dcache (
		.clk(clk),
		.reset(reset),
		.dreq(dreq),
		.dresp(dresp),
		.creq(creq),
		.cresp(cresp)
	);

	cbus_memory #(
		.MEM_WORDS(MEM_WORDS),
		.RESP_DELAY(RESP_DELAY)
	) u_memory (
		.clk(clk),
		.reset(reset),
		.creq(creq),
		.cresp(cresp)
	);

endmodule

`default_nettype wire

//--- verilog/single_port_ram.sv
`timescale 1ns/100ps
`default_nettype none

module single_port_ram #(
	parameter type data_t = logic [63:0],
	parameter int DEPTH = 16
) (
	input  logic clk,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  logic [($bits(data_t) + 7) / 8 - 1:0] strobe,
	input  data_t wdata,
	output data_t rdata
);

	localparam int WIDTH = $bits(data_t);
	localparam int BYTES = (WIDTH + 7) / 8;

	// storage rounded up to whole bytes
	logic [BYTES*8-1:0] mem [DEPTH];
	logic [BYTES*8-1:0] wide_wdata;
	logic [BYTES*8-1:0] rword;

	assign wide_wdata = (BYTES*8)'(wdata);

	// read returns the old contents on a same-address write
	always_ff @(posedge clk) begin
		for (int b = 0; b < BYTES; b++) begin
			if (strobe[b]) begin
				mem[addr][b*8 +: 8] <= wide_wdata[b*8 +: 8];
			end
		end
		rword <= mem[addr];
	end

	assign rdata = data_t'(rword[WIDTH-1:0]);

endmodule

`default_nettype wire
